//--- rtl/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// Widths
`define UART_DATA_W        8
`define UART_ADDR_W        3
`define UART_DIV_W         16

// Baud timing
`define UART_PRESCALE      27    // 50 MHz / 27 / 16 is close to 115200 baud
`define UART_OVERSAMPLE    16    // Ticks per bit time
`define UART_SAMPLE_POINT  7     // Mid-bit tick
`define UART_FRAME_BITS    11    // Start, 8 data, parity slot, stop

// Register map
`define UART_ADDR_DATA     3'd0  // THR/RBR, divisor low with baud_select
`define UART_ADDR_IER      3'd1  // IER, divisor high with baud_select
`define UART_ADDR_LCR      3'd3
`define UART_ADDR_LSR      3'd5

// LSR bits, bit 4 reads 0
`define UART_LSR_DR        0
`define UART_LSR_OE        1
`define UART_LSR_PE        2
`define UART_LSR_FE        3
`define UART_LSR_THRE      5
`define UART_LSR_TEMT      6
`define UART_LSR_ERR       7

// IER bits
`define UART_IER_RX        0
`define UART_IER_THRE      1
`define UART_IER_LS        2

`endif

//--- rtl/uart_pkg.sv
`include "uart_defs.svh"

package uart_pkg;

	typedef logic [`UART_DATA_W-1:0] byte_t;

	// Line control register, MSB first
	typedef struct packed {
		logic       baud_select;    // Addresses 0 and 1 map to the divisor latch
		logic       brk;            // Kept for readback
		logic       parity_forced;
		logic       parity_even;
		logic       parity_enable;
		logic       stop;           // Kept for readback
		logic [1:0] word_len;       // Kept for readback
	} lcr_t;

	typedef enum logic [2:0] {
		PAR_NONE,
		PAR_ODD,
		PAR_EVEN,
		PAR_MARK,
		PAR_SPACE
	} parity_e;

	// Value of the parity slot for a data byte
	function automatic logic parity_slot(parity_e mode, byte_t data);
		case (mode)
			PAR_ODD:   return ~(^data);   // Odd count of ones overall
			PAR_EVEN:  return ^data;
			PAR_SPACE: return 1'b0;
			default:   return 1'b1;       // Mark, also the idle slot without parity
		endcase
	endfunction

endpackage

//--- rtl/uart_baud_gen.sv
`include "uart_defs.svh"

module uart_baud_gen (
	input  logic                   CLK,
	input  logic                   reset,
	input  logic [`UART_DIV_W-1:0] div_value,   // Divisor latch contents
	input  logic                   div_load,    // Divisor byte written
	output logic                   tick16       // 16x bit rate strobe
);

	localparam int PRE_W = $clog2(`UART_PRESCALE);

	logic [PRE_W-1:0]       pre_cnt;
	logic                   pre_carry;
	logic [`UART_DIV_W-1:0] div_cnt;
	logic [`UART_DIV_W-1:0] div_top;     // Last divisor count before wrap

	assign pre_carry = (pre_cnt == PRE_W'(`UART_PRESCALE - 1));
	assign div_top   = (div_value == '0) ? '0 : div_value - 1'b1;   // Zero acts as one

	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
		begin
			pre_cnt <= '0;
			div_cnt <= '0;
			tick16  <= 1'b0;
		end
		else if (div_load)
		begin
			// New divisor, restart both stages
			pre_cnt <= '0;
			div_cnt <= '0;
			tick16  <= 1'b0;
		end
		else
		begin
			tick16 <= 1'b0;
			if (pre_carry)
			begin
				pre_cnt <= '0;
				if (div_cnt >= div_top)   // Also catches a shrunk divisor
				begin
					div_cnt <= '0;
					tick16  <= 1'b1;
				end
				else
					div_cnt <= div_cnt + 1'b1;
			end
			else
				pre_cnt <= pre_cnt + 1'b1;
		end
	end

	// Receiver and transmitter count each tick once
	assert property (@(posedge CLK) disable iff (reset) tick16 |=> !tick16)
		else $error("tick16 high on consecutive cycles");

endmodule

//--- rtl/uart_rx.sv
`include "uart_defs.svh"

module uart_rx (
	input  logic              CLK,
	input  logic              reset,
	input  logic              tick16,       // 16x bit rate strobe
	input  logic              rxd,          // Serial line in
	input  uart_pkg::parity_e parity,
	output uart_pkg::byte_t   rx_data,      // Held until next frame end
	output logic              rx_done,      // Frame end pulse
	output logic              parity_err,
	output logic              frame_err     // Stop bit sampled low
);

	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W  = $clog2(`UART_FRAME_BITS);

	logic [2:0]        filt;         // Line filter stages
	logic              line;         // Filtered line
	logic              busy;         // Frame in progress
	logic [TICK_W-1:0] tick_cnt;     // Tick index inside the bit
	logic [BIT_W-1:0]  bit_cnt;      // Samples taken so far
	logic              sample;
	logic [9:0]        shift;        // Data, parity slot, stop
	logic              frame_end;    // Last sample shifted in

	assign line   = filt[2];
	assign sample = tick16 & busy & (tick_cnt == TICK_W'(`UART_SAMPLE_POINT));

	// Three stage filter stepped on the tick
	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
			filt <= 3'b111;   // Idle line is mark
		else if (tick16)
		begin
			if ((filt[0] == filt[2]) && (filt[0] != filt[1]))
				filt[2] <= filt[0];   // Drop a one-tick glitch
			else
				filt[2] <= filt[1];
			filt[1] <= filt[0];
			filt[0] <= rxd;
		end
	end

	// Start detection and mid-bit sample timing
	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
		begin
			busy      <= 1'b0;
			tick_cnt  <= '0;
			bit_cnt   <= '0;
			frame_end <= 1'b0;
		end
		else
		begin
			frame_end <= 1'b0;
			if (tick16)
			begin
				if (!busy)
				begin
					if (!line)
					begin
						busy     <= 1'b1;
						tick_cnt <= TICK_W'(1);   // Detecting tick counts as index 0
						bit_cnt  <= '0;
					end
				end
				else
				begin
					tick_cnt <= tick_cnt + 1'b1;   // Wraps once per bit
					if (sample)
					begin
						if (bit_cnt == BIT_W'(`UART_FRAME_BITS - 1))
						begin
							busy      <= 1'b0;   // Stop bit taken
							frame_end <= 1'b1;
						end
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
				end
			end
		end
	end

	// Start bit falls off the bottom after all 11 samples
	always_ff @(posedge CLK)
	begin
		if (sample)
			shift <= {line, shift[9:1]};
	end

	// End of frame checks
	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
		begin
			rx_data    <= '0;
			rx_done    <= 1'b0;
			parity_err <= 1'b0;
			frame_err  <= 1'b0;
		end
		else
		begin
			rx_done <= frame_end;
			if (frame_end)
			begin
				rx_data    <= shift[7:0];
				parity_err <= (parity != uart_pkg::PAR_NONE) &&
					(shift[8] != uart_pkg::parity_slot(parity, shift[7:0]));
				frame_err  <= ~shift[9];
			end
		end
	end

	// Data ready and overrun count frames by this pulse
	assert property (@(posedge CLK) disable iff (reset) rx_done |=> !rx_done)
		else $error("rx_done longer than one cycle");

endmodule

//--- rtl/uart_tx.sv
`include "uart_defs.svh"

module uart_tx (
	input  logic              CLK,
	input  logic              reset,
	input  logic              tick16,       // 16x bit rate strobe
	input  logic              tx_load,      // THR write
	input  uart_pkg::byte_t   tx_data,
	input  uart_pkg::parity_e parity,
	output logic              txd,          // Serial line out
	output logic              thr_empty,
	output logic              tx_idle       // Nothing held, nothing shifting
);

	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W  = $clog2(`UART_FRAME_BITS);

	uart_pkg::byte_t             thr;          // Holding register
	logic                        thr_full;
	logic [TICK_W-1:0]           div_cnt;      // Ticks within the bit
	logic                        bit_tick;
	logic                        tx_on;        // Frame on the line
	logic [BIT_W-1:0]            bit_cnt;
	logic                        load_shift;
	logic [`UART_FRAME_BITS-1:0] shift;        // LSB is the line

	assign bit_tick   = tick16 & (div_cnt == TICK_W'(`UART_OVERSAMPLE - 1));
	assign load_shift = bit_tick & ~tx_on & thr_full;
	assign txd        = shift[0];
	assign thr_empty  = ~thr_full;
	assign tx_idle    = ~tx_on & ~thr_full;

	always_ff @(posedge CLK)
	begin
		if (tx_load)
			thr <= tx_data;   // Overwrites any unsent byte
	end

	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
		begin
			thr_full <= 1'b0;
			div_cnt  <= '0;
			tx_on    <= 1'b0;
			bit_cnt  <= '0;
			shift    <= '1;   // Line at mark
		end
		else
		begin
			// New write wins over the move into the shifter
			if (tx_load)
				thr_full <= 1'b1;
			else if (load_shift)
				thr_full <= 1'b0;

			if (tick16)
				div_cnt <= div_cnt + 1'b1;

			if (load_shift)
			begin
				// Stop, parity slot, data, start
				shift   <= {1'b1, uart_pkg::parity_slot(parity, thr), thr, 1'b0};
				tx_on   <= 1'b1;
				bit_cnt <= '0;
			end
			else if (bit_tick && tx_on)
			begin
				shift <= {1'b1, shift[`UART_FRAME_BITS-1:1]};   // Ones fill behind
				if (bit_cnt == BIT_W'(`UART_FRAME_BITS - 1))
					tx_on <= 1'b0;   // Stop bit done
				else
					bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// TEMT in LSR promises a quiet line
	assert property (@(posedge CLK) disable iff (reset) tx_idle |-> txd)
		else $error("txd low while transmitter idle");

endmodule

//--- rtl/uart_regs.sv
`include "uart_defs.svh"

module uart_regs (
	input  logic                    CLK,
	input  logic                    reset,
	input  logic                    CS,
	input  logic                    nRW,          // 1 writes
	input  logic [`UART_ADDR_W-1:0] add,
	input  uart_pkg::byte_t         data_in,
	input  uart_pkg::byte_t         rx_data,
	input  logic                    rx_done,
	input  logic                    parity_err,
	input  logic                    frame_err,
	input  logic                    thr_empty,
	input  logic                    tx_idle,
	output uart_pkg::byte_t         data_out,
	output logic                    nIRQ,
	output logic [`UART_DIV_W-1:0]  div_value,
	output logic                    div_load,
	output logic                    tx_load,
	output uart_pkg::byte_t         tx_data,
	output uart_pkg::parity_e       parity
);

	uart_pkg::lcr_t          lcr;
	logic [`UART_IER_LS:0]   ier;
	logic                    wr;
	logic                    rd;
	logic                    dll_wr;      // Divisor low byte
	logic                    dlm_wr;      // Divisor high byte
	logic                    ier_wr;
	logic                    lcr_wr;
	logic                    rx_read;     // Receive data read
	logic                    lsr_read;
	logic                    dr;          // Data ready
	logic                    oe;          // Overrun
	logic                    err;
	uart_pkg::byte_t         lsr;

	assign wr = CS & nRW;
	assign rd = CS & ~nRW;

	// baud_select swaps addresses 0 and 1 over to the divisor latch
	assign tx_load  = wr & (add == `UART_ADDR_DATA) & ~lcr.baud_select;
	assign dll_wr   = wr & (add == `UART_ADDR_DATA) & lcr.baud_select;
	assign dlm_wr   = wr & (add == `UART_ADDR_IER) & lcr.baud_select;
	assign ier_wr   = wr & (add == `UART_ADDR_IER) & ~lcr.baud_select;
	assign lcr_wr   = wr & (add == `UART_ADDR_LCR);
	assign rx_read  = rd & (add == `UART_ADDR_DATA) & ~lcr.baud_select;
	assign lsr_read = rd & (add == `UART_ADDR_LSR);
	assign div_load = dll_wr | dlm_wr;
	assign tx_data  = data_in;

	always_ff @(posedge CLK or posedge reset)
	begin
		if (reset)
		begin
			lcr       <= '0;
			ier       <= '0;
			div_value <= `UART_DIV_W'(1);
			dr        <= 1'b0;
			oe        <= 1'b0;
		end
		else
		begin
			if (lcr_wr)
				lcr <= uart_pkg::lcr_t'(data_in);
			if (ier_wr)
				ier <= data_in[`UART_IER_LS:0];
			if (dll_wr)
				div_value[7:0] <= data_in;
			if (dlm_wr)
				div_value[15:8] <= data_in;

			// A new frame beats a read in the same cycle
			if (rx_done)
				dr <= 1'b1;
			else if (rx_read)
				dr <= 1'b0;
			if (rx_done && dr)
				oe <= 1'b1;   // Unread byte lost
			else if (lsr_read)
				oe <= 1'b0;
		end
	end

	// LCR parity fields to mode
	always_comb
	begin
		if (!lcr.parity_enable)
			parity = uart_pkg::PAR_NONE;
		else if (!lcr.parity_forced)
			parity = lcr.parity_even ? uart_pkg::PAR_EVEN : uart_pkg::PAR_ODD;
		else
			parity = lcr.parity_even ? uart_pkg::PAR_SPACE : uart_pkg::PAR_MARK;
	end

	assign err = parity_err | frame_err | oe;

	always_comb
	begin
		lsr = '0;
		lsr[`UART_LSR_DR]   = dr;
		lsr[`UART_LSR_OE]   = oe;
		lsr[`UART_LSR_PE]   = parity_err;
		lsr[`UART_LSR_FE]   = frame_err;
		lsr[`UART_LSR_THRE] = thr_empty;
		lsr[`UART_LSR_TEMT] = tx_idle;
		lsr[`UART_LSR_ERR]  = err;
	end

	// Read mux, zero outside mapped reads
	always_comb
	begin
		data_out = '0;
		if (rd)
			case (add)
				`UART_ADDR_DATA: data_out = lcr.baud_select ? div_value[7:0] : rx_data;
				`UART_ADDR_IER:  data_out = lcr.baud_select ? div_value[15:8] :
					uart_pkg::byte_t'(ier);
				`UART_ADDR_LCR:  data_out = lcr;
				`UART_ADDR_LSR:  data_out = lsr;
				default:         data_out = '0;
			endcase
	end

	// Level interrupt, low active
	assign nIRQ = ~((ier[`UART_IER_RX] & dr) | (ier[`UART_IER_THRE] & thr_empty) |
		(ier[`UART_IER_LS] & err));

	assert property (@(posedge CLK) disable iff (reset) !(tx_load && div_load))
		else $error("tx_load and div_load together");

endmodule

//--- rtl/uart_top.sv
`include "uart_defs.svh"

module uart_top (
	input  logic                    CLK,
	input  logic                    reset,
	input  logic                    CS,          // Chip select
	input  logic                    nRW,         // 1 writes
	input  logic [`UART_ADDR_W-1:0] add,
	input  uart_pkg::byte_t         data_in,
	input  logic                    RxD,
	output uart_pkg::byte_t         data_out,
	output logic                    TxD,
	output logic                    nIRQ         // Low while an enabled source is active
);

	logic [`UART_DIV_W-1:0] div_value;
	logic                   div_load;
	logic                   tick16;       // Shared by both directions
	logic                   tx_load;
	uart_pkg::byte_t        tx_data;
	uart_pkg::byte_t        rx_data;
	uart_pkg::parity_e      parity;
	logic                   rx_done;
	logic                   parity_err;
	logic                   frame_err;
	logic                   thr_empty;
	logic                   tx_idle;

	uart_baud_gen u_baud_gen (
		.CLK       (CLK),
		.reset     (reset),
		.div_value (div_value),
		.div_load  (div_load),
		.tick16    (tick16)
	);

	uart_rx u_rx (
		.CLK        (CLK),
		.reset      (reset),
		.tick16     (tick16),
		.rxd        (RxD),
		.parity     (parity),
		.rx_data    (rx_data),
		.rx_done    (rx_done),
		.parity_err (parity_err),
		.frame_err  (frame_err)
	);

	uart_tx u_tx (
		.CLK       (CLK),
		.reset     (reset),
		.tick16    (tick16),
		.tx_load   (tx_load),
		.tx_data   (tx_data),
		.parity    (parity),
		.txd       (TxD),
		.thr_empty (thr_empty),
		.tx_idle   (tx_idle)
	);

	uart_regs u_regs (
		.CLK        (CLK),
		.reset      (reset),
		.CS         (CS),
		.nRW        (nRW),
		.add        (add),
		.data_in    (data_in),
		.rx_data    (rx_data),
		.rx_done    (rx_done),
		.parity_err (parity_err),
		.frame_err  (frame_err),
		.thr_empty  (thr_empty),
		.tx_idle    (tx_idle),
		.data_out   (data_out),
		.nIRQ       (nIRQ),
		.div_value  (div_value),
		.div_load   (div_load),
		.tx_load    (tx_load),
		.tx_data    (tx_data),
		.parity     (parity)
	);

endmodule

//--- dv/uart_tb.sv
`include "uart_defs.svh"

module uart_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_NS       = 8;
	localparam int RESET_CYCLES = 5;
	localparam int BIT_CYCLES_1 = `UART_OVERSAMPLE * `UART_PRESCALE;   // Bit time at divisor 1
	localparam int FRAME_NS     = `UART_FRAME_BITS * BIT_CYCLES_1 * CLK_NS;
	// Transmit 10, loopback 5, receive errors 8 with the quiet gap, overrun 2,
	// interrupt 2, divisor frame at half speed 2
	localparam int TEST_FRAMES  = 10 + 5 + 8 + 2 + 2 + 2;
	localparam int WATCHDOG_NS  = 2 * TEST_FRAMES * FRAME_NS + RESET_CYCLES * CLK_NS;

	logic                    CLK;
	logic                    reset;
	logic                    cs;
	logic                    n_rw;
	logic [`UART_ADDR_W-1:0] add;
	uart_pkg::byte_t         data_in;
	uart_pkg::byte_t         data_out;
	logic                    rxd;
	logic                    txd;
	logic                    n_irq;
	logic                    loop_sel;      // 1 feeds TxD back to RxD
	logic                    drv_line;      // Serial driver output
	int                      cur_div;       // Divisor the DUT runs with
	int                      mismatches;
	int                      timeouts;
	int                      other_errs;
	logic [15:0]             lfsr;
	logic [`UART_FRAME_BITS-1:0] frame_q[$];   // Frames expected on TxD

	assign rxd = loop_sel ? txd : drv_line;

	uart_top u_dut (
		.CLK      (CLK),
		.reset    (reset),
		.CS       (cs),
		.nRW      (n_rw),
		.add      (add),
		.data_in  (data_in),
		.RxD      (rxd),
		.data_out (data_out),
		.TxD      (txd),
		.nIRQ     (n_irq)
	);

	initial
	begin
		CLK = 1'b0;
		forever #(CLK_NS / 2) CLK = ~CLK;
	end

	// Galois form, taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		else
			return s >> 1;
	endfunction

	function automatic int bit_cycles();
		return BIT_CYCLES_1 * cur_div;
	endfunction

	// Start, data LSB first, parity slot, stop
	function automatic logic [`UART_FRAME_BITS-1:0] frame_of(input uart_pkg::byte_t b,
		input uart_pkg::parity_e mode);
		int   ones;
		logic slot;
		ones = 0;
		for (int i = 0; i < `UART_DATA_W; i++)
			ones += b[i];
		case (mode)
			uart_pkg::PAR_ODD:   slot = (ones % 2 == 0);   // Odd total with the slot
			uart_pkg::PAR_EVEN:  slot = (ones % 2 == 1);
			uart_pkg::PAR_SPACE: slot = 1'b0;
			default:             slot = 1'b1;              // Mark, also no parity
		endcase
		return {1'b1, slot, b, 1'b0};
	endfunction

	function automatic uart_pkg::byte_t lcr_of(input uart_pkg::parity_e mode);
		case (mode)
			uart_pkg::PAR_ODD:   return 8'h08;
			uart_pkg::PAR_EVEN:  return 8'h18;
			uart_pkg::PAR_MARK:  return 8'h28;
			uart_pkg::PAR_SPACE: return 8'h38;
			default:             return 8'h00;
		endcase
	endfunction

	function automatic uart_pkg::byte_t lsr_of(input logic dr, input logic oe, input logic pe,
		input logic fe, input logic thre, input logic temt);
		uart_pkg::byte_t v;
		v = '0;
		v[`UART_LSR_DR]   = dr;
		v[`UART_LSR_OE]   = oe;
		v[`UART_LSR_PE]   = pe;
		v[`UART_LSR_FE]   = fe;
		v[`UART_LSR_THRE] = thre;
		v[`UART_LSR_TEMT] = temt;
		v[`UART_LSR_ERR]  = oe | pe | fe;   // Any error
		return v;
	endfunction

	// Low while any enabled source is active
	function automatic logic irq_of(input uart_pkg::byte_t ier, input logic dr,
		input logic thre, input logic err);
		return ~((ier[`UART_IER_RX] & dr) | (ier[`UART_IER_THRE] & thre) |
			(ier[`UART_IER_LS] & err));
	endfunction

	task automatic rand_byte(output uart_pkg::byte_t b);
		b = '0;
		for (int i = 0; i < `UART_DATA_W; i++)
		begin
			lfsr = lfsr_step(lfsr);   // One step per bit
			b = {b[`UART_DATA_W-2:0], lfsr[0]};
		end
	endtask

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			mismatches++;
			$display("Mismatch at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual,
				expected);
		end
	endtask

	// Bus tasks start and end 1 ns after a rising edge
	task automatic write_reg(input logic [`UART_ADDR_W-1:0] a, input uart_pkg::byte_t d);
		cs      = 1'b1;
		n_rw    = 1'b1;
		add     = a;
		data_in = d;
		@(posedge CLK);
		#1;
		cs   = 1'b0;
		n_rw = 1'b0;
	endtask

	task automatic read_reg(input logic [`UART_ADDR_W-1:0] a, output uart_pkg::byte_t d);
		cs   = 1'b1;
		n_rw = 1'b0;
		add  = a;
		#2;
		d = data_out;   // Mid-cycle, mux settled
		@(posedge CLK);
		#1;
		cs = 1'b0;
	endtask

	// Poll LSR until a bit sets, bounded by three frame times
	task automatic wait_lsr(input int bit_idx, input string what);
		uart_pkg::byte_t v;
		int              polls;
		v     = '0;
		polls = 0;
		while (v[bit_idx] !== 1'b1 && polls < 3 * `UART_FRAME_BITS * bit_cycles())
		begin
			read_reg(`UART_ADDR_LSR, v);
			polls++;
		end
		if (v[bit_idx] !== 1'b1)
		begin
			timeouts++;
			$display("Timeout at %0t: %s did not happen in time", $time, what);
		end
	endtask

	task automatic send_byte(input uart_pkg::byte_t b, input uart_pkg::parity_e mode);
		frame_q.push_back(frame_of(b, mode));
		write_reg(`UART_ADDR_DATA, b);
	endtask

	task automatic drive_frame(input uart_pkg::byte_t b, input uart_pkg::parity_e mode,
		input logic bad_parity, input logic bad_stop);
		logic [`UART_FRAME_BITS-1:0] f;
		f = frame_of(b, mode);
		if (bad_parity)
			f[9] = ~f[9];
		if (bad_stop)
			f[10] = 1'b0;
		for (int i = 0; i < `UART_FRAME_BITS; i++)
		begin
			drv_line = f[i];
			repeat (bit_cycles()) @(posedge CLK);
			#1;
		end
		drv_line = 1'b1;   // Back to mark
	endtask

	task automatic report_counts();
		$display("Errors: %0d mismatches, %0d timeouts, %0d other failures", mismatches,
			timeouts, other_errs);
	endtask

	// TxD monitor, samples on falling CLK away from line changes
	initial
	begin : tx_monitor
		logic [`UART_FRAME_BITS-1:0] got;
		logic [`UART_FRAME_BITS-1:0] exp;
		forever
		begin
			@(negedge txd);
			repeat (bit_cycles() / 2) @(negedge CLK);   // Middle of start bit
			got[0] = txd;
			for (int i = 1; i < `UART_FRAME_BITS; i++)
			begin
				repeat (bit_cycles()) @(negedge CLK);
				got[i] = txd;
			end
			if (frame_q.size() == 0)
			begin
				other_errs++;
				$display("Unexpected frame 0x%0h seen on TxD at %0t", got, $time);
			end
			else
			begin
				exp = frame_q.pop_front();
				compare(got, exp, "frame on TxD");
			end
		end
	end

	initial
	begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		report_counts();
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin : main
		uart_pkg::byte_t   b;
		uart_pkg::byte_t   b2;
		uart_pkg::byte_t   v;
		uart_pkg::parity_e mode;
		$timeformat(-9, 0, " ns", 0);
		reset      = 1'b1;
		cs         = 1'b0;
		n_rw       = 1'b0;
		add        = '0;
		data_in    = '0;
		drv_line   = 1'b1;
		loop_sel   = 1'b0;
		cur_div    = 1;
		lfsr       = 16'd13;
		mismatches = 0;
		timeouts   = 0;
		other_errs = 0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		reset = 1'b0;

		// Reset state
		compare(txd, 1'b1, "TxD after reset");
		compare(n_irq, irq_of(8'h00, 1'b0, 1'b1, 1'b0), "nIRQ after reset");
		read_reg(`UART_ADDR_LCR, v);
		compare(v, 8'h00, "LCR after reset");
		read_reg(`UART_ADDR_LSR, v);
		compare(v, lsr_of(0, 0, 0, 0, 1, 1), "LSR after reset");

		// Transmit, two bytes per parity mode
		for (int m = 0; m < 5; m++)
		begin
			mode = uart_pkg::parity_e'(m);
			write_reg(`UART_ADDR_LCR, lcr_of(mode));
			repeat (2)
			begin
				rand_byte(b);
				send_byte(b, mode);
				wait_lsr(`UART_LSR_TEMT, "transmitter idle");
				read_reg(`UART_ADDR_LSR, v);
				compare(v, lsr_of(0, 0, 0, 0, 1, 1), "LSR after transmit");
			end
		end

		// Loopback, TEMT may still be low when data ready sets
		loop_sel = 1'b1;
		for (int m = 0; m < 5; m++)
		begin
			mode = uart_pkg::parity_e'(m);
			write_reg(`UART_ADDR_LCR, lcr_of(mode));
			rand_byte(b);
			send_byte(b, mode);
			wait_lsr(`UART_LSR_DR, "loopback data ready");
			read_reg(`UART_ADDR_DATA, v);
			compare(v, b, "loopback data");
			read_reg(`UART_ADDR_LSR, v);
			compare(v & 8'h0D, lsr_of(0, 0, 0, 0, 1, 1) & 8'h0D, "LSR DR, PE, FE after loopback");
			wait_lsr(`UART_LSR_TEMT, "transmitter idle after loopback");
		end
		loop_sel = 1'b0;

		// Flipped parity slot in every parity mode
		for (int m = 1; m < 5; m++)
		begin
			mode = uart_pkg::parity_e'(m);
			write_reg(`UART_ADDR_LCR, lcr_of(mode));
			rand_byte(b);
			drive_frame(b, mode, 1'b1, 1'b0);
			read_reg(`UART_ADDR_LSR, v);
			compare(v, lsr_of(1, 0, 1, 0, 1, 1), "LSR after bad parity");
			read_reg(`UART_ADDR_DATA, v);
			compare(v, b, "data of bad parity frame");
		end

		// Low stop bit
		mode = uart_pkg::PAR_EVEN;
		write_reg(`UART_ADDR_LCR, lcr_of(mode));
		rand_byte(b);
		drive_frame(b, mode, 1'b0, 1'b1);
		read_reg(`UART_ADDR_LSR, v);
		compare(v, lsr_of(1, 0, 0, 1, 1, 1), "LSR after low stop bit");
		read_reg(`UART_ADDR_DATA, v);
		compare(v, b, "data of low stop frame");
		// Low stop looks like a new start, let that frame run out
		repeat (13 * bit_cycles()) @(posedge CLK);
		#1;
		read_reg(`UART_ADDR_DATA, v);
		read_reg(`UART_ADDR_LSR, v);
		rand_byte(b);
		drive_frame(b, mode, 1'b0, 1'b0);
		read_reg(`UART_ADDR_LSR, v);
		compare(v, lsr_of(1, 0, 0, 0, 1, 1), "LSR after good frame");
		read_reg(`UART_ADDR_DATA, v);
		compare(v, b, "data of good frame");

		// Overrun
		mode = uart_pkg::PAR_NONE;
		write_reg(`UART_ADDR_LCR, lcr_of(mode));
		rand_byte(b);
		rand_byte(b2);
		drive_frame(b, mode, 1'b0, 1'b0);
		drive_frame(b2, mode, 1'b0, 1'b0);   // First byte never read
		read_reg(`UART_ADDR_LSR, v);
		compare(v, lsr_of(1, 1, 0, 0, 1, 1), "LSR after overrun");
		read_reg(`UART_ADDR_LSR, v);
		compare(v, lsr_of(1, 0, 0, 0, 1, 1), "LSR after overrun cleared");
		read_reg(`UART_ADDR_DATA, v);
		compare(v, b2, "data after overrun");

		// Receive interrupt
		write_reg(`UART_ADDR_IER, 8'h01);
		compare(n_irq, irq_of(8'h01, 1'b0, 1'b1, 1'b0), "nIRQ before receive");
		rand_byte(b);
		drive_frame(b, mode, 1'b0, 1'b0);
		compare(n_irq, irq_of(8'h01, 1'b1, 1'b1, 1'b0), "nIRQ with data ready");
		read_reg(`UART_ADDR_DATA, v);
		compare(v, b, "data with receive interrupt");
		compare(n_irq, irq_of(8'h01, 1'b0, 1'b1, 1'b0), "nIRQ after data read");

		// Empty interrupt
		write_reg(`UART_ADDR_IER, 8'h02);
		compare(n_irq, irq_of(8'h02, 1'b0, 1'b1, 1'b0), "nIRQ with THR empty");
		rand_byte(b);
		send_byte(b, mode);
		compare(n_irq, irq_of(8'h02, 1'b0, 1'b0, 1'b0), "nIRQ with THR full");
		wait_lsr(`UART_LSR_TEMT, "transmitter idle with empty interrupt");
		compare(n_irq, irq_of(8'h02, 1'b0, 1'b1, 1'b0), "nIRQ after transmit");
		write_reg(`UART_ADDR_IER, 8'h00);

		// Divisor 2, twice the bit time
		write_reg(`UART_ADDR_LCR, 8'h80);
		write_reg(`UART_ADDR_DATA, 8'h02);
		write_reg(`UART_ADDR_IER, 8'h00);
		read_reg(`UART_ADDR_DATA, v);
		compare(v, 8'h02, "divisor low readback");
		write_reg(`UART_ADDR_LCR, lcr_of(mode));
		cur_div = 2;
		rand_byte(b);
		send_byte(b, mode);
		wait_lsr(`UART_LSR_TEMT, "transmitter idle at divisor 2");
		compare(frame_q.size(), 0, "frames never seen on TxD");

		report_counts();
		if (mismatches + timeouts + other_errs == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- uart_top.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_baud_gen.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_regs.sv
rtl/uart_top.sv
dv/uart_tb.sv

//--- Bender.yml
package:
  name: uart_top

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/uart_pkg.sv
      - rtl/uart_baud_gen.sv
      - rtl/uart_rx.sv
      - rtl/uart_tx.sv
      - rtl/uart_regs.sv
      - rtl/uart_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/uart_tb.sv
